// ==== hdl/memsys_pkg.sv ====
// Memory interconnect shared types, address map, access sizes and host command codes
package memsys_pkg;

    // Plain vector types for widths that carry a meaning
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;

    // Load/store control, coded like RISC-V funct3
    // [1:0] is the access size, [2] set selects zero extension
    typedef logic [2:0]   ctrl_t;

    // Decoded target of a CPU access
    // Each value is also the address nibble [31:28] that selects it
    typedef enum logic [3:0] {
        DEV_DRAM  = 4'h0,
        DEV_PLIC  = 4'h5,
        DEV_CLINT = 4'h6,
        DEV_NONE  = 4'hf
    } dev_sel_t;

    // Address nibbles that map onto DRAM
    localparam logic [3:0] DEV_DRAM_LO = 4'h0;
    localparam logic [3:0] DEV_DRAM_HI = 4'h8;

    // 128 MB DRAM window
    localparam addr_t DRAM_OFFSET_MASK = 32'h07ff_ffff;

    // Access sizes in ctrl_t[1:0]
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // Word store, used for every boot image write
    localparam ctrl_t CTRL_SW = {1'b0, SIZE_WORD};

    // Host interface
    localparam addr_t       TOHOST_ADDR    = 32'h4000_8000;
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0200;

endpackage

// ==== hdl/boot_loader.sv ====
// Boot loader sequencer that places the kernel image and device tree into DRAM
`timescale 1ns/1ps

module boot_loader #(
    parameter memsys_pkg::addr_t BBL_SIZE  = 32'h0080_0000,
    parameter memsys_pkg::addr_t DTB_START = 32'h0100_0000,
    parameter memsys_pkg::addr_t DTB_SIZE  = 32'h0000_2000
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              loader_we,
    input  memsys_pkg::word_t loader_data,
    output memsys_pkg::addr_t boot_addr,
    output logic              boot_we,
    output memsys_pkg::word_t boot_wdata,
    output logic              init_done
);

    localparam memsys_pkg::addr_t DTB_END = DTB_START + DTB_SIZE;

    typedef enum logic [1:0] {
        INIT_BBL,
        INIT_DTB,
        INIT_DONE
    } init_state_t;

    init_state_t       state;
    memsys_pkg::addr_t bbl_addr;
    memsys_pkg::addr_t dtb_addr;
    logic              bbl_full;
    logic              dtb_full;
    logic              to_dtb;

    assign bbl_full = (bbl_addr >= BBL_SIZE);
    assign dtb_full = (dtb_addr >= DTB_END);

    // Kernel region ends as soon as its counter is full, even before the state moves on
    assign to_dtb = (state == INIT_DTB) || bbl_full;

    // Region counters, one word per loader strobe
    always_ff @(posedge CLK) begin
        if (rst) begin
            bbl_addr <= '0;
            dtb_addr <= DTB_START;
        end else if (boot_we) begin
            if (to_dtb) begin
                dtb_addr <= dtb_addr + 32'd4;
            end else begin
                bbl_addr <= bbl_addr + 32'd4;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= INIT_BBL;
        end else begin
            case (state)
                INIT_BBL: if (bbl_full) state <= INIT_DTB;
                INIT_DTB: if (dtb_full) state <= INIT_DONE;
                default:  state <= INIT_DONE;
            endcase
        end
    end

    assign boot_we    = loader_we && (state != INIT_DONE);
    assign boot_addr  = to_dtb ? dtb_addr : bbl_addr;
    assign boot_wdata = loader_data;
    assign init_done  = (state == INIT_DONE);

endmodule

// ==== hdl/bus_arbiter.sv ====
// DRAM bus arbiter between the boot loader and the CPU data port
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 init_done,
    input  logic                 boot_we,
    input  memsys_pkg::addr_t    boot_addr,
    input  memsys_pkg::word_t    boot_wdata,
    input  memsys_pkg::addr_t    cpu_addr,
    input  memsys_pkg::word_t    cpu_wdata,
    input  memsys_pkg::ctrl_t    cpu_ctrl,
    input  logic                 cpu_we,
    input  logic                 cpu_re,
    input  memsys_pkg::dev_sel_t dev_sel,
    input  logic                 dram_busy,
    output logic                 dram_rd_en,
    output logic                 dram_wr_en,
    output memsys_pkg::addr_t    dram_addr,
    output memsys_pkg::word_t    dram_wdata,
    output memsys_pkg::ctrl_t    dram_ctrl,
    output logic                 proc_busy,
    output logic                 access
);

    logic cpu_grant;
    logic dram_sel;

    // Strobe ownership passes to the CPU one cycle after boot completes,
    // so the final loader write has fully left the bus
    always_ff @(posedge CLK) begin
        if (rst) begin
            cpu_grant <= 1'b0;
        end else begin
            cpu_grant <= init_done;
        end
    end

    assign dram_sel  = (dev_sel == memsys_pkg::DEV_DRAM);
    assign proc_busy = !cpu_grant || dram_busy;
    assign access    = (cpu_we || cpu_re) && !proc_busy;

    // Request strobes
    always_comb begin
        if (cpu_grant) begin
            dram_wr_en = cpu_we && dram_sel && !dram_busy;
            dram_rd_en = cpu_re && dram_sel && !dram_busy;
        end else begin
            dram_wr_en = boot_we;
            dram_rd_en = 1'b0;
        end
    end

    // Request payload
    always_comb begin
        if (init_done) begin
            dram_addr  = cpu_addr & memsys_pkg::DRAM_OFFSET_MASK;
            dram_wdata = cpu_wdata;
            dram_ctrl  = cpu_ctrl;
        end else begin
            dram_addr  = boot_addr;
            dram_wdata = boot_wdata;
            dram_ctrl  = memsys_pkg::CTRL_SW;
        end
    end

endmodule

// ==== hdl/addr_decoder.sv ====
// CPU address decoder that selects DRAM, PLIC or CLINT and strobes the device windows
`timescale 1ns/1ps

module addr_decoder (
    input  memsys_pkg::addr_t    cpu_addr,
    input  logic                 cpu_we,
    input  logic                 cpu_re,
    input  logic                 proc_busy,
    output memsys_pkg::dev_sel_t dev_sel,
    output logic                 plic_we,
    output logic                 plic_re,
    output logic                 clint_we
);

    logic [3:0] dev_nib;
    logic       wr_ok;
    logic       rd_ok;
    logic       hit_plic;
    logic       hit_clint;

    assign dev_nib = cpu_addr[31:28];

    // Target from the top address nibble
    always_comb begin
        case (dev_nib)
            memsys_pkg::DEV_DRAM_LO,
            memsys_pkg::DEV_DRAM_HI: begin
                dev_sel = memsys_pkg::DEV_DRAM;
            end
            memsys_pkg::DEV_PLIC: begin
                dev_sel = memsys_pkg::DEV_PLIC;
            end
            memsys_pkg::DEV_CLINT: begin
                dev_sel = memsys_pkg::DEV_CLINT;
            end
            default: begin
                dev_sel = memsys_pkg::DEV_NONE;
            end
        endcase
    end

    // Only an access that is accepted this cycle reaches a device
    assign wr_ok = cpu_we && !proc_busy;
    assign rd_ok = cpu_re && !proc_busy;

    assign hit_plic  = (dev_sel == memsys_pkg::DEV_PLIC);
    assign hit_clint = (dev_sel == memsys_pkg::DEV_CLINT);

    assign plic_we  = wr_ok && hit_plic;
    assign plic_re  = rd_ok && hit_plic;

    // CLINT reads need no strobe, its data is always presented
    assign clint_we = wr_ok && hit_clint;

endmodule

// ==== hdl/load_align.sv ====
// Load data formatter that slices DRAM lines and selects device read data
`timescale 1ns/1ps

module load_align (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 access,
    input  memsys_pkg::addr_t    cpu_addr,
    input  memsys_pkg::ctrl_t    cpu_ctrl,
    input  memsys_pkg::dev_sel_t dev_sel,
    input  memsys_pkg::line_t    dram_rdata,
    input  memsys_pkg::word_t    plic_rdata,
    input  memsys_pkg::word_t    clint_rdata,
    output memsys_pkg::word_t    data_rdata
);

    logic [3:0]           off_q;
    memsys_pkg::ctrl_t    ctrl_q;
    memsys_pkg::dev_sel_t dev_q;
    memsys_pkg::line_t    line_sh;
    memsys_pkg::word_t    word_raw;
    memsys_pkg::word_t    dram_word;
    logic                 sign_en;

    // Access attributes held until the next access
    always_ff @(posedge CLK) begin
        if (access) begin
            off_q  <= cpu_addr[3:0];
            ctrl_q <= cpu_ctrl;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            dev_q <= memsys_pkg::DEV_NONE;
        end else if (access) begin
            dev_q <= dev_sel;
        end
    end

    // Byte offset within the 16-byte line
    assign line_sh  = dram_rdata >> {off_q, 3'b000};
    assign word_raw = line_sh[31:0];
    assign sign_en  = !ctrl_q[2];

    always_comb begin
        case (ctrl_q[1:0])
            memsys_pkg::SIZE_BYTE: dram_word = {{24{word_raw[7] & sign_en}}, word_raw[7:0]};
            memsys_pkg::SIZE_HALF: dram_word = {{16{word_raw[15] & sign_en}}, word_raw[15:0]};
            default:               dram_word = word_raw;
        endcase
    end

    always_comb begin
        case (dev_q)
            memsys_pkg::DEV_DRAM:  data_rdata = dram_word;
            memsys_pkg::DEV_PLIC:  data_rdata = plic_rdata;
            memsys_pkg::DEV_CLINT: data_rdata = clint_rdata;
            default:               data_rdata = '0;
        endcase
    end

endmodule

// ==== hdl/tohost_ctrl.sv ====
// Tohost command register for console characters and simulation power-off
`timescale 1ns/1ps

module tohost_ctrl (
    input  logic              CLK,
    input  logic              rst,
    input  memsys_pkg::addr_t mem_addr,
    input  logic              mem_we,
    input  memsys_pkg::word_t mem_wdata,
    output logic              uart_we,
    output logic [7:0]        uart_data,
    output logic              finish
);

    memsys_pkg::word_t tohost_q;
    logic              tohost_hit;
    logic [15:0]       cmd;
    logic              is_print;
    logic              wr_power_off;

    assign tohost_hit = mem_we && (mem_addr == memsys_pkg::TOHOST_ADDR);

    // Command code sits in the upper half
    assign cmd      = tohost_q[31:16];
    assign is_print = (cmd == memsys_pkg::CMD_PRINT_CHAR);

    assign wr_power_off = tohost_hit && (mem_wdata[31:16] == memsys_pkg::CMD_POWER_OFF);

    // A print command lives for one cycle, then the register clears.
    // A new write wins over the clear
    always_ff @(posedge CLK) begin
        if (rst) begin
            tohost_q <= '0;
        end else if (tohost_hit) begin
            tohost_q <= mem_wdata;
        end else if (is_print) begin
            tohost_q <= '0;
        end
    end

    // Power-off is sticky until reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            finish <= 1'b0;
        end else if (wr_power_off) begin
            finish <= 1'b1;
        end
    end

    // Character pulse straight from the held command
    assign uart_we   = is_print;
    assign uart_data = tohost_q[7:0];

endmodule

// ==== hdl/mem_interconnect.sv ====
// Memory interconnect top joining boot loading, CPU access decode, load formatting and tohost
`timescale 1ns/1ps

module mem_interconnect #(
    parameter memsys_pkg::addr_t BBL_SIZE  = 32'h0080_0000,
    parameter memsys_pkg::addr_t DTB_START = 32'h0100_0000,
    parameter memsys_pkg::addr_t DTB_SIZE  = 32'h0000_2000
) (
    input  logic              CLK,
    input  logic              rst,
    // Boot image loader
    input  logic              loader_we,
    input  memsys_pkg::word_t loader_data,
    // CPU data port
    input  memsys_pkg::addr_t cpu_addr,
    input  memsys_pkg::word_t cpu_wdata,
    input  logic              cpu_we,
    input  logic              cpu_re,
    input  memsys_pkg::ctrl_t cpu_ctrl,
    output logic              proc_busy,
    // DRAM
    output logic              dram_rd_en,
    output logic              dram_wr_en,
    output memsys_pkg::addr_t dram_addr,
    output memsys_pkg::word_t dram_wdata,
    output memsys_pkg::ctrl_t dram_ctrl,
    input  logic              dram_busy,
    input  memsys_pkg::line_t dram_rdata,
    // PLIC
    output logic              plic_we,
    output logic              plic_re,
    output memsys_pkg::word_t plic_wdata,
    input  memsys_pkg::word_t plic_rdata,
    // CLINT
    output logic              clint_we,
    output memsys_pkg::word_t clint_wdata,
    input  memsys_pkg::word_t clint_rdata,
    // Results
    output memsys_pkg::word_t data_rdata,
    output logic              init_done,
    output logic              uart_we,
    output logic [7:0]        uart_data,
    output logic              finish
);

    memsys_pkg::addr_t    boot_addr;
    logic                 boot_we;
    memsys_pkg::word_t    boot_wdata;
    memsys_pkg::dev_sel_t dev_sel;
    logic                 access;
    logic                 mem_we;

    assign plic_wdata  = cpu_wdata;
    assign clint_wdata = cpu_wdata;

    // Only accepted CPU stores reach the tohost register
    assign mem_we = cpu_we && access;

    boot_loader #(
        .BBL_SIZE  (BBL_SIZE),
        .DTB_START (DTB_START),
        .DTB_SIZE  (DTB_SIZE)
    ) boot_loader0 (
        .CLK(CLK), .rst(rst), .loader_we(loader_we), .loader_data(loader_data),
        .boot_addr(boot_addr), .boot_we(boot_we), .boot_wdata(boot_wdata), .init_done(init_done)
    );

    addr_decoder addr_decoder0 (
        .cpu_addr(cpu_addr), .cpu_we(cpu_we), .cpu_re(cpu_re), .proc_busy(proc_busy),
        .dev_sel(dev_sel), .plic_we(plic_we), .plic_re(plic_re), .clint_we(clint_we)
    );

    bus_arbiter bus_arbiter0 (
        .CLK(CLK), .rst(rst), .init_done(init_done),
        .boot_we(boot_we), .boot_addr(boot_addr), .boot_wdata(boot_wdata),
        .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_ctrl(cpu_ctrl),
        .cpu_we(cpu_we), .cpu_re(cpu_re), .dev_sel(dev_sel), .dram_busy(dram_busy),
        .dram_rd_en(dram_rd_en), .dram_wr_en(dram_wr_en), .dram_addr(dram_addr),
        .dram_wdata(dram_wdata), .dram_ctrl(dram_ctrl), .proc_busy(proc_busy), .access(access)
    );

    load_align load_align0 (
        .CLK(CLK), .rst(rst), .access(access), .cpu_addr(cpu_addr), .cpu_ctrl(cpu_ctrl),
        .dev_sel(dev_sel), .dram_rdata(dram_rdata), .plic_rdata(plic_rdata),
        .clint_rdata(clint_rdata), .data_rdata(data_rdata)
    );

    tohost_ctrl tohost_ctrl0 (
        .CLK(CLK), .rst(rst), .mem_addr(cpu_addr), .mem_we(mem_we), .mem_wdata(cpu_wdata),
        .uart_we(uart_we), .uart_data(uart_data), .finish(finish)
    );

endmodule

// ==== tb/tb_mem_interconnect.sv ====
// Testbench for the memory interconnect with DRAM, PLIC and CLINT models and reference checks
`timescale 1ns/1ps

module tb_mem_interconnect;

    localparam int BBL_SIZE  = 32;
    localparam int DTB_START = 64;
    localparam int DTB_SIZE  = 16;
    localparam int N_BOOT  = (BBL_SIZE + DTB_SIZE) / 4;
    localparam int N_STORE = 24;
    localparam int N_UNMAP = 8;
    localparam int N_LOAD  = 32;
    localparam int N_DEV   = 16;
    localparam int N_HOST  = 4;
    localparam int CYCLE_LIMIT = 20 * (N_BOOT + N_STORE + N_UNMAP + N_LOAD + N_DEV + N_HOST);

    logic CLK, rst, loader_we, cpu_we, cpu_re, proc_busy, dram_rd_en, dram_wr_en, dram_busy;
    logic plic_we, plic_re, clint_we, init_done, uart_we, finish;
    logic [7:0] uart_data;
    memsys_pkg::word_t loader_data, cpu_wdata, dram_wdata, plic_wdata, plic_rdata;
    memsys_pkg::word_t clint_wdata, clint_rdata, data_rdata;
    memsys_pkg::addr_t cpu_addr, dram_addr;
    memsys_pkg::ctrl_t cpu_ctrl, dram_ctrl;
    memsys_pkg::line_t dram_rdata;

    // DRAM model state
    memsys_pkg::word_t dram_mem [0:255];
    int   busy_left = 0;
    logic strobe_seen = 1'b0;
    logic read_seen = 1'b0;

    logic [31:0] lfsr = 32'h34d5;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles = 0;

    mem_interconnect #(.BBL_SIZE(BBL_SIZE), .DTB_START(DTB_START), .DTB_SIZE(DTB_SIZE)) dut0 (
        .CLK(CLK), .rst(rst), .loader_we(loader_we), .loader_data(loader_data),
        .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_we(cpu_we), .cpu_re(cpu_re),
        .cpu_ctrl(cpu_ctrl), .proc_busy(proc_busy), .dram_rd_en(dram_rd_en),
        .dram_wr_en(dram_wr_en), .dram_addr(dram_addr), .dram_wdata(dram_wdata),
        .dram_ctrl(dram_ctrl), .dram_busy(dram_busy), .dram_rdata(dram_rdata),
        .plic_we(plic_we), .plic_re(plic_re), .plic_wdata(plic_wdata), .plic_rdata(plic_rdata),
        .clint_we(clint_we), .clint_wdata(clint_wdata), .clint_rdata(clint_rdata),
        .data_rdata(data_rdata), .init_done(init_done), .uart_we(uart_we),
        .uart_data(uart_data), .finish(finish)
    );

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the test sequence did not complete within %0d cycles", cycles);
            $display("Checks: %0d, errors: %0d", n_checks, n_errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [1:0] pick_size();
        logic [1:0] s;
        s = 2'd3;
        while (s == 2'd3) s = rand_bits(2);
        return s;
    endfunction

    // Nibbles that select DRAM, PLIC or CLINT
    function automatic logic is_mapped(input logic [3:0] nib);
        return (nib == 4'h0) || (nib == 4'h5) || (nib == 4'h6) || (nib == 4'h8);
    endfunction

    // Byte address of the n-th boot word in the kernel region or the device tree
    function automatic int boot_word_addr(input int n);
        if (n * 4 < BBL_SIZE) begin
            return n * 4;
        end
        return DTB_START + n * 4 - BBL_SIZE;
    endfunction

    // Reference load takes the line slice at the byte offset and extends it per ctrl[2]
    function automatic memsys_pkg::word_t load_expect(input memsys_pkg::line_t line,
                                                      input logic [3:0] off,
                                                      input memsys_pkg::ctrl_t ctrl);
        logic [7:0]  b;
        logic [15:0] h;
        b = line[off*8 +: 8];
        h = line[off*8 +: 16];
        case (ctrl[1:0])
            2'd0:    return ctrl[2] ? {24'h0, b} : {{24{b[7]}}, b};
            2'd1:    return ctrl[2] ? {16'h0, h} : {{16{h[15]}}, h};
            default: return line[off*8 +: 32];
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // DRAM model reacts on the falling edge to the strobe seen in the previous cycle
    task automatic tick();
        @(negedge CLK);
        if (strobe_seen) busy_left = rand_bits(2);
        if (read_seen) dram_rdata = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        dram_busy = (busy_left != 0);
        if (dram_busy) busy_left--;
    endtask

    // Outputs are settled a quarter period before the rising edge
    task automatic sample();
        #10;
        if (dram_busy) begin
            check("proc_busy", proc_busy, 1);
            check("dram_wr_en", dram_wr_en, 0);
            check("dram_rd_en", dram_rd_en, 0);
        end
        if (dram_wr_en) dram_mem[dram_addr[9:2]] = dram_wdata;
        strobe_seen = dram_wr_en || dram_rd_en;
        read_seen = dram_rd_en;
    endtask

    // Holds one CPU access until accepted, checks the strobes, then idles one cycle
    task automatic cpu_access(input logic we, input logic re, input memsys_pkg::addr_t addr,
                              input memsys_pkg::word_t wdata, input memsys_pkg::ctrl_t ctrl);
        logic is_dram;
        is_dram = (addr[31:28] == memsys_pkg::DEV_DRAM_LO)
                  || (addr[31:28] == memsys_pkg::DEV_DRAM_HI);
        cpu_addr = addr;
        cpu_wdata = wdata;
        cpu_ctrl = ctrl;
        cpu_we = we;
        cpu_re = re;
        sample();
        while (proc_busy) begin
            check("dram_wr_en", dram_wr_en, 0);
            check("dram_rd_en", dram_rd_en, 0);
            check("plic_we", plic_we, 0);
            check("clint_we", clint_we, 0);
            tick();
            sample();
        end
        check("dram_wr_en", dram_wr_en, we && is_dram);
        check("dram_rd_en", dram_rd_en, re && is_dram);
        check("plic_we", plic_we, we && (addr[31:28] == memsys_pkg::DEV_PLIC));
        check("plic_re", plic_re, re && (addr[31:28] == memsys_pkg::DEV_PLIC));
        check("clint_we", clint_we, we && (addr[31:28] == memsys_pkg::DEV_CLINT));
        if (we) begin
            check("plic_wdata", plic_wdata, wdata);
            check("clint_wdata", clint_wdata, wdata);
        end
        if (is_dram) begin
            check("dram_addr", dram_addr, addr & memsys_pkg::DRAM_OFFSET_MASK);
            check("dram_wdata", dram_wdata, wdata);
            check("dram_ctrl", dram_ctrl, ctrl);
        end
        check("uart_we", uart_we, 0);
        check("finish", finish, 0);
        tick();
        cpu_we = 1'b0;
        cpu_re = 1'b0;
        sample();
    endtask

    initial begin : stimulus
        int i;
        memsys_pkg::addr_t addr;
        memsys_pkg::ctrl_t ctrl;
        memsys_pkg::word_t boot_img [0:N_BOOT-1];
        logic [1:0] kind;
        logic [3:0] off;
        logic [7:0] ch;
        rst = 1'b1;
        {loader_we, cpu_we, cpu_re, dram_busy} = '0;
        {loader_data, cpu_addr, cpu_wdata, cpu_ctrl, plic_rdata, clint_rdata} = '0;
        dram_rdata = '0;
        repeat (8) @(posedge CLK);
        tick();
        rst = 1'b0;
        sample();
        check("{init_done,dram_rd_en,dram_wr_en,plic_we,plic_re,clint_we,uart_we,finish}",
              {init_done, dram_rd_en, dram_wr_en, plic_we, plic_re, clint_we, uart_we, finish}, 0);

        // Boot image goes to the kernel region and then to the device tree
        i = 0;
        while (i < N_BOOT) begin
            tick();
            loader_we = !dram_busy;
            loader_data = rand_bits(32);
            sample();
            if (loader_we) begin
                check("dram_wr_en", dram_wr_en, 1);
                check("dram_addr", dram_addr, boot_word_addr(i));
                check("dram_wdata", dram_wdata, loader_data);
                check("dram_ctrl", dram_ctrl, memsys_pkg::CTRL_SW);
                check("proc_busy", proc_busy, 1);
                check("init_done", init_done, 0);
                boot_img[i] = loader_data;
                i++;
            end
        end
        tick();
        loader_we = 1'b0;
        sample();
        while (!init_done) begin
            check("proc_busy", proc_busy, 1);
            tick();
            sample();
        end

        // Boot image as it stands in the DRAM model once boot is done
        for (i = 0; i < N_BOOT; i++) begin
            addr = boot_word_addr(i);
            check("dram_mem", dram_mem[addr[9:2]], boot_img[i]);
        end

        for (i = 0; i < N_STORE; i++) begin
            ctrl = {1'b0, pick_size()};
            off = rand_bits(4) & ~((4'd1 << ctrl[1:0]) - 4'd1);
            addr = rand_bits(32);
            addr[31:28] = rand_bits(1) ? memsys_pkg::DEV_DRAM_HI : memsys_pkg::DEV_DRAM_LO;
            addr[3:0] = off;
            tick();
            cpu_access(1'b1, 1'b0, addr, rand_bits(32), ctrl);
        end

        // Stores and reads alternate across the unmapped windows
        for (i = 0; i < N_UNMAP; i++) begin
            addr = rand_bits(32);
            while (is_mapped(addr[31:28])) begin
                addr[31:28] = rand_bits(4);
            end
            tick();
            cpu_access(i % 2 == 0, i % 2 == 1, addr, rand_bits(32), memsys_pkg::CTRL_SW);
            if (i % 2 == 1) check("data_rdata", data_rdata, 0);
        end

        for (i = 0; i < N_LOAD; i++) begin
            ctrl[1:0] = pick_size();
            ctrl[2] = rand_bits(1);
            off = rand_bits(4) & ~((4'd1 << ctrl[1:0]) - 4'd1);
            addr = rand_bits(32);
            addr[31:28] = rand_bits(1) ? memsys_pkg::DEV_DRAM_HI : memsys_pkg::DEV_DRAM_LO;
            addr[3:0] = off;
            tick();
            cpu_access(1'b0, 1'b1, addr, '0, ctrl);
            while (dram_busy) begin
                tick();
                sample();
            end
            check("data_rdata", data_rdata, load_expect(dram_rdata, off, ctrl));
        end

        // kind[1] picks the PLIC or CLINT window and kind[0] a read
        for (i = 0; i < N_DEV; i++) begin
            kind = rand_bits(2);
            addr = rand_bits(32);
            addr[31:28] = kind[1] ? memsys_pkg::DEV_CLINT : memsys_pkg::DEV_PLIC;
            addr[1:0] = 2'b00;
            tick();
            plic_rdata = rand_bits(32);
            clint_rdata = rand_bits(32);
            cpu_access(!kind[0], kind[0], addr, rand_bits(32), memsys_pkg::CTRL_SW);
            if (kind[0]) check("data_rdata", data_rdata, kind[1] ? clint_rdata : plic_rdata);
        end

        for (i = 0; i < N_HOST - 1; i++) begin
            ch = rand_bits(8);
            tick();
            cpu_access(1'b1, 1'b0, memsys_pkg::TOHOST_ADDR, {memsys_pkg::CMD_PRINT_CHAR, 8'h00, ch},
                       memsys_pkg::CTRL_SW);
            check("uart_we", uart_we, 1);
            check("uart_data", uart_data, ch);
            tick();
            sample();
            check("uart_we", uart_we, 0);
        end
        tick();
        cpu_access(1'b1, 1'b0, memsys_pkg::TOHOST_ADDR, {memsys_pkg::CMD_POWER_OFF, 16'h0000},
                   memsys_pkg::CTRL_SW);
        check("finish", finish, 1);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hdl/memsys_pkg.sv
hdl/boot_loader.sv
hdl/bus_arbiter.sv
hdl/addr_decoder.sv
hdl/load_align.sv
hdl/tohost_ctrl.sv
hdl/mem_interconnect.sv
tb/tb_mem_interconnect.sv

// ==== Bender.yml ====
package:
  name: mem_interconnect

sources:
  - files:
      - hdl/memsys_pkg.sv
      - hdl/boot_loader.sv
      - hdl/bus_arbiter.sv
      - hdl/addr_decoder.sv
      - hdl/load_align.sv
      - hdl/tohost_ctrl.sv
      - hdl/mem_interconnect.sv
  - target: simulation
    files:
      - tb/tb_mem_interconnect.sv
